// File: Makefile
# Verilator build, run, lint and clean for the array heap
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := heapArrayTb
FILELIST  := heapArray.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: heapArray.f
+incdir+verif
hw/heapPkg.sv
hw/heapStageIf.sv
hw/heapDecode.sv
hw/heapExecute.sv
hw/heapResult.sv
hw/heapArray.sv
verif/heapArrayTb.sv

// File: hw/heapArray.sv
// Array heap top level
// Three stages: decode with bookkeeping, element execute, result registers
// Stages joined by two interfaces, plain ports outside
`timescale 1ns/1ps
`default_nettype none

module heapArray (
  input  wire                clock,
  input  wire                resetN,
  input  wire                start,     // One-cycle request strobe
  input  wire heapPkg::heapAction action,
  input  wire heapPkg::arrayNum   array,
  input  wire heapPkg::elemIndex  index,
  input  wire heapPkg::elemData   dataIn,
  output heapPkg::elemData        dataOut,
  output heapPkg::heapError       error,
  output logic                    done  // Pulses 3 cycles after start
);

  decodeToExecIf decToExec ();  // Decode to execute
  execToResultIf execToRes ();  // Execute to result

  // --------------------
  // Stages
  // --------------------
  heapDecode heapDecode_i (
    .clock  (clock),
    .resetN (resetN),
    .start  (start),
    .action (action),
    .array  (array),
    .index  (index),
    .dataIn (dataIn),
    .toExec (decToExec.producer)
  );

  heapExecute heapExecute_i (
    .clock      (clock),
    .resetN     (resetN),
    .fromDecode (decToExec.consumer),
    .toResult   (execToRes.producer)
  );

  heapResult heapResult_i (
    .clock    (clock),
    .resetN   (resetN),
    .fromExec (execToRes.consumer),
    .dataOut  (dataOut),
    .error    (error),
    .done     (done)
  );

endmodule

`default_nettype wire

// File: hw/heapDecode.sv
// Decode stage
// Request capture, action decode and access checks
// Allocation flags, size table and freed-array stack
`timescale 1ns/1ps
`default_nettype none

module heapDecode (
  input  wire                     clock,
  input  wire                     resetN,
  input  wire                     start,
  input  wire heapPkg::heapAction action,
  input  wire heapPkg::arrayNum   array,
  input  wire heapPkg::elemIndex  index,
  input  wire heapPkg::elemData   dataIn,
  decodeToExecIf.producer         toExec
);
  import heapPkg::*;

  logic      reqValid;                   // Captured request
  heapAction reqAction;
  arrayNum   reqArray;
  elemIndex  reqIndex;
  elemData   reqData;

  logic               allocated  [arrayCount];  // Array in use
  arraySize           sizes      [arrayCount];
  arrayNum            freedStack [arrayCount];  // Freed arrays for reuse
  logic [arrayBits:0] freedTop;                 // Stack depth
  logic [arrayBits:0] handedOut;                // Never-used arrays given out

  arraySize curSize;
  heapError writeErr;     // Array checks only
  heapError readErr;      // Plus bounds
  elemOp    nextOp;
  elemIndex nextIndex;
  heapError nextError;
  elemData  nextPass;
  logic     nextHasData;
  logic     setSize;
  arrayNum  sizeTarget;   // Differs from request on alloc
  arraySize newSize;
  logic     doAlloc;
  logic     fromFreed;
  arrayNum  allocNum;
  logic     doFree;
  logic     doClear;
  logic     commit;       // Bookkeeping takes effect

  function automatic elemOp toElemOp(heapAction act);
    case (act)
      actAdd:      return opAdd;
      actAddAfter: return opAddAfter;
      actSub:      return opSub;
      actSubAfter: return opSubAfter;
      actShl:      return opShl;
      actShr:      return opShr;
      actLNot:     return opLNot;
      actNot:      return opNot;
      actOr:       return opOr;
      actXor:      return opXor;
      default:     return opAnd;
    endcase
  endfunction

  // --------------------
  // Checks, later failures override earlier ones
  // --------------------
  assign curSize = sizes[reqArray];

  always_comb begin
    writeErr = errNone;
    if ({1'b0, reqArray} >= handedOut) writeErr = errNotAllocated;
    if (!allocated[reqArray]) writeErr = errFreed;
    readErr = writeErr;
    if ({1'b0, reqIndex} >= curSize) readErr = errBounds;
  end

  // --------------------
  // Action decode
  // --------------------
  always_comb begin
    nextOp      = opNone;
    nextIndex   = reqIndex;
    nextError   = writeErr;   // Most actions need a live array
    nextPass    = elemData'(curSize);
    nextHasData = 1'b0;
    setSize     = 1'b0;
    sizeTarget  = reqArray;
    newSize     = curSize;
    doAlloc     = 1'b0;
    fromFreed   = 1'b0;
    allocNum    = reqArray;
    doFree      = 1'b0;
    doClear     = 1'b0;
    case (reqAction)
      actClear: begin
        nextError = errNone;
        doClear   = 1'b1;
      end
      actWrite: begin
        nextOp      = opWrite;
        nextHasData = 1'b1;
        setSize     = {1'b0, reqIndex} >= curSize;  // Extend past the end
        newSize     = {1'b0, reqIndex} + 1'b1;
      end
      actRead: begin
        nextError   = readErr;
        nextOp      = opRead;
        nextHasData = 1'b1;
      end
      actSize: nextHasData = 1'b1;
      actInc, actPush: begin
        if (writeErr == errNone && int'(curSize) == arrayLength) nextError = errFull;
        setSize   = 1'b1;
        newSize   = curSize + 1'b1;
        nextIndex = elemIndex'(curSize);            // Push slot
        if (reqAction == actPush) nextOp = opWrite;
      end
      actDec, actPop: begin
        if (writeErr == errNone && curSize == '0) nextError = errEmpty;
        setSize   = 1'b1;
        newSize   = curSize - 1'b1;
        nextIndex = elemIndex'(curSize - 1'b1);     // Top element
        if (reqAction == actPop) begin
          nextOp      = opRead;
          nextHasData = 1'b1;
        end
      end
      actResize: begin
        if (writeErr == errNone && int'(reqData) > arrayLength) nextError = errBounds;
        setSize = 1'b1;
        newSize = arraySize'(reqData);
      end
      actAlloc: begin
        nextError   = errNone;
        doAlloc     = 1'b1;
        nextHasData = 1'b1;
        if (freedTop != '0) begin                   // Reuse first
          fromFreed = 1'b1;
          allocNum  = freedStack[arrayNum'(freedTop - 1'b1)];
        end else if (int'(handedOut) < arrayCount) begin
          allocNum  = arrayNum'(handedOut);
        end else begin
          nextError = errNoMemory;
        end
        setSize    = 1'b1;
        sizeTarget = allocNum;
        newSize    = '0;                            // New array starts empty
        nextPass   = elemData'(allocNum);
      end
      actFree: doFree = 1'b1;
      actAdd, actAddAfter, actSub, actSubAfter, actShl, actShr,
      actLNot, actNot, actOr, actXor, actAnd: begin
        nextError   = readErr;
        nextOp      = toElemOp(reqAction);
        nextHasData = 1'b1;
      end
      default: nextError = errBadAction;
    endcase
  end

  assign commit = reqValid && (nextError == errNone);

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      reqValid     <= 1'b0;
      toExec.valid <= 1'b0;
      freedTop     <= '0;
      handedOut    <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        allocated[i] <= 1'b0;
        sizes[i]     <= '0;
      end
    end else begin
      reqValid     <= start;
      toExec.valid <= reqValid;
      if (commit && doClear) begin                  // Forget all arrays
        freedTop  <= '0;
        handedOut <= '0;
        for (int i = 0; i < arrayCount; i++) sizes[i] <= '0;
      end
      if (commit && setSize) sizes[sizeTarget] <= newSize;
      if (commit && doAlloc) begin
        allocated[allocNum] <= 1'b1;
        if (fromFreed) freedTop <= freedTop - 1'b1;
        else handedOut <= handedOut + 1'b1;
      end
      if (commit && doFree) begin
        allocated[reqArray] <= 1'b0;
        freedTop            <= freedTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin                                // Capture request
      reqAction <= action;
      reqArray  <= array;
      reqIndex  <= index;
      reqData   <= dataIn;
    end
    if (reqValid) begin
      toExec.op       <= nextOp;
      toExec.array    <= reqArray;
      toExec.index    <= nextIndex;
      toExec.operand  <= reqData;
      toExec.failed   <= nextError != errNone;
      toExec.error    <= nextError;
      toExec.passData <= nextPass;
      toExec.hasData  <= nextHasData;
    end
    if (commit && doFree) freedStack[arrayNum'(freedTop)] <= reqArray;
  end

  // Free only pushes live arrays, so the stack stays within the array count
  assert property (@(posedge clock) disable iff (!resetN) int'(freedTop) <= arrayCount)
    else $error("Freed stack overflow");

  for (genvar g = 0; g < arrayCount; g++) begin : sizeCheck
    assert property (@(posedge clock) disable iff (!resetN) int'(sizes[g]) <= arrayLength)
      else $error("Array size beyond maximum length");
  end

endmodule

`default_nettype wire

// File: hw/heapExecute.sv
// Execute stage
// Element memory, one entry per array and index
// Read-modify-write of one element per item
`timescale 1ns/1ps
`default_nettype none

module heapExecute (
  input wire              clock,
  input wire              resetN,
  decodeToExecIf.consumer fromDecode,
  execToResultIf.producer toResult
);
  import heapPkg::*;

  elemData mem [arrayCount][arrayLength];  // Element storage
  elemData oldValue;                       // Element before the op
  elemData newValue;                       // Element after the op
  elemData outValue;                       // Value reported
  logic    memWrite;

  assign oldValue = mem[fromDecode.array][fromDecode.index];

  // --------------------
  // Element operation
  // --------------------
  always_comb begin
    case (fromDecode.op)
      opWrite:           newValue = fromDecode.operand;
      opAdd, opAddAfter: newValue = oldValue + fromDecode.operand;
      opSub, opSubAfter: newValue = oldValue - fromDecode.operand;
      opShl:             newValue = oldValue << fromDecode.operand;  // Operand is shift count
      opShr:             newValue = oldValue >> fromDecode.operand;
      opLNot:            newValue = elemData'(oldValue == '0);       // One when zero
      opNot:             newValue = ~oldValue;
      opOr:              newValue = oldValue | fromDecode.operand;
      opXor:             newValue = oldValue ^ fromDecode.operand;
      opAnd:             newValue = oldValue & fromDecode.operand;
      default:           newValue = oldValue;
    endcase
  end

  always_comb begin
    case (fromDecode.op)
      opNone:                         outValue = fromDecode.passData;  // Size or array number
      opRead, opAddAfter, opSubAfter: outValue = oldValue;             // Value before update
      default:                        outValue = newValue;
    endcase
  end

  assign memWrite = fromDecode.valid && !fromDecode.failed &&
                    fromDecode.op != opNone && fromDecode.op != opRead;

  always_ff @(posedge clock) begin
    if (memWrite) mem[fromDecode.array][fromDecode.index] <= newValue;
  end

  // --------------------
  // Response registers
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      toResult.valid <= 1'b0;
    end else begin
      toResult.valid <= fromDecode.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (fromDecode.valid) begin
      toResult.data    <= outValue;
      toResult.hasData <= fromDecode.hasData;
      toResult.error   <= fromDecode.error;              // Failures pass straight on
    end
  end

  // A rejected request leaves its element as it was
  assert property (@(posedge clock) disable iff (!resetN)
    (fromDecode.valid && fromDecode.failed) |=>
      mem[$past(fromDecode.array)][$past(fromDecode.index)] === $past(oldValue))
    else $error("Failed item changed element memory");

endmodule

`default_nettype wire

// File: hw/heapPkg.sv
// Heap package
// Sizes of the array memory, vector types for indices and data
// Action codes, error kinds and element operations
`default_nettype none

package heapPkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int arrayBits   = 2;               // Bits in an array number
  localparam int arrayCount  = 2 ** arrayBits;  // Arrays held in memory
  localparam int indexBits   = 3;               // Bits in an element index
  localparam int arrayLength = 2 ** indexBits;  // Max elements per array
  localparam int dataWidth   = 12;              // Element width

  // --------------------
  // Vector types
  // --------------------
  typedef logic [arrayBits-1:0] arrayNum;       // Array number
  typedef logic [indexBits-1:0] elemIndex;      // Index within an array
  typedef logic [indexBits:0]   arraySize;      // Size 0 to arrayLength
  typedef logic [dataWidth-1:0] elemData;       // Element or operand

  // Request codes, numbered as in the older heap
  typedef enum logic [7:0] {
    actClear    = 8'd1,   actWrite    = 8'd2,   actRead     = 8'd3,
    actSize     = 8'd4,   actInc      = 8'd5,   actDec      = 8'd6,
    actPush     = 8'd14,  actPop      = 8'd15,  actResize   = 8'd17,
    actAlloc    = 8'd18,  actFree     = 8'd19,  actAdd      = 8'd20,
    actAddAfter = 8'd21,  actSub      = 8'd22,  actSubAfter = 8'd23,
    actShl      = 8'd24,  actShr      = 8'd25,  actLNot     = 8'd26,
    actNot      = 8'd27,  actOr       = 8'd28,  actXor      = 8'd29,
    actAnd      = 8'd30
  } heapAction;

  typedef enum logic [2:0] {
    errNone         = 3'd0,  // Request completed
    errNotAllocated = 3'd1,  // Array beyond those handed out
    errFreed        = 3'd2,  // Array was freed
    errBounds       = 3'd3,  // Index or new size too large
    errFull         = 3'd4,  // Inc or push on full array
    errEmpty        = 3'd5,  // Dec or pop on empty array
    errNoMemory     = 3'd6,  // No array left to allocate
    errBadAction    = 3'd7   // Unknown action code
  } heapError;

  // Element operation handed from decode to execute
  typedef enum logic [3:0] {
    opNone, opWrite, opRead, opAdd, opAddAfter, opSub, opSubAfter,
    opShl, opShr, opLNot, opNot, opOr, opXor, opAnd
  } elemOp;

endpackage

`default_nettype wire

// File: hw/heapResult.sv
// Result stage
// Output registers for data, error kind and done pulse
`timescale 1ns/1ps
`default_nettype none

module heapResult (
  input  wire                 clock,
  input  wire                 resetN,
  execToResultIf.consumer     fromExec,
  output heapPkg::elemData    dataOut,
  output heapPkg::heapError   error,
  output logic                done
);
  import heapPkg::*;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      dataOut <= '0;
      error   <= errNone;
      done    <= 1'b0;
    end else begin
      done <= fromExec.valid;                     // One pulse per item
      if (fromExec.valid) begin
        error <= fromExec.error;
        // Failed and no-data items keep the last value
        if (fromExec.hasData && fromExec.error == errNone) dataOut <= fromExec.data;
      end
    end
  end

  // Back-to-back done only for back-to-back responses
  assert property (@(posedge clock) disable iff (!resetN)
    (done && $past(done)) |-> ($past(fromExec.valid) && $past(fromExec.valid, 2)))
    else $error("Done held without a response behind it");

endmodule

`default_nettype wire

// File: hw/heapStageIf.sv
// Stage interfaces
// decodeToExecIf carries decoded items into execute
// execToResultIf carries responses into the result registers
`timescale 1ns/1ps
`default_nettype none

interface decodeToExecIf;
  import heapPkg::*;

  logic     valid;     // Item present
  elemOp    op;        // Element operation to run
  arrayNum  array;     // Target array
  elemIndex index;     // Resolved index, push and pop included
  elemData  operand;   // Request data
  logic     failed;    // A check failed
  heapError error;
  elemData  passData;  // Size or array number when no element op
  logic     hasData;   // Response updates dataOut

  modport producer (output valid, op, array, index, operand,
                    output failed, error, passData, hasData);
  modport consumer (input  valid, op, array, index, operand,
                    input  failed, error, passData, hasData);
endinterface

interface execToResultIf;
  import heapPkg::*;

  logic     valid;     // Response present
  elemData  data;      // Value to report
  logic     hasData;   // Value replaces dataOut
  heapError error;

  modport producer (output valid, data, hasData, error);
  modport consumer (input  valid, data, hasData, error);
endinterface

`default_nettype wire

// File: verif/heapArrayTests.svh
// Reference model of the array heap
// Directed tests: allocation, write and read, push and pop,
// element operations, back-to-back requests, unknown actions
`ifndef HEAP_ARRAY_TESTS_SVH
`define HEAP_ARRAY_TESTS_SVH

  // --------------------
  // Reference model
  // --------------------
  logic    modelAllocated [arrayCount] = '{default: 1'b0};
  int      modelSize      [arrayCount] = '{default: 0};
  int      modelFreed     [$];                      // Last freed on top
  int      modelHandedOut = 0;
  elemData modelMem [arrayCount][arrayLength] = '{default: '0};
  elemData modelLast = '0;                          // Expected dataOut

  function automatic elemData applyOp(input heapAction act, input elemData old,
                                      input elemData operand);
    case (act)
      actAdd, actAddAfter: return old + operand;
      actSub, actSubAfter: return old - operand;
      actShl:              return old << operand;   // Operand is the shift count
      actShr:              return old >> operand;
      actLNot:             return (old == '0) ? elemData'(1) : elemData'(0);
      actNot:              return ~old;
      actOr:               return old | operand;
      actXor:              return old ^ operand;
      actAnd:              return old & operand;
      default:             return old;
    endcase
  endfunction

  task automatic modelStep(input heapAction act, input int arr, input int idx,
                           input elemData val, output heapError expErr,
                           output elemData expData);
    heapError arrErr;
    heapError readErr;
    heapError err;
    elemData  result;
    elemData  old;
    logic     hasData;
    int       slot;
    arrErr = errNone;                                // Later checks win
    if (arr >= modelHandedOut) arrErr = errNotAllocated;
    if (!modelAllocated[arr]) arrErr = errFreed;
    readErr = (idx >= modelSize[arr]) ? errBounds : arrErr;
    err     = arrErr;
    result  = '0;
    hasData = 1'b1;
    case (act)
      actClear: begin
        err     = errNone;
        hasData = 1'b0;
        modelHandedOut = 0;
        modelFreed.delete();
        foreach (modelSize[i]) modelSize[i] = 0;
      end
      actWrite: begin
        result = val;
        if (err == errNone) begin
          modelMem[arr][idx] = val;
          if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;  // Grow to cover index
        end
      end
      actRead: begin
        err    = readErr;
        result = modelMem[arr][idx];
      end
      actSize: result = elemData'(modelSize[arr]);
      actInc, actPush: begin
        hasData = 1'b0;
        if (err == errNone && modelSize[arr] == arrayLength) err = errFull;
        if (err == errNone) begin
          if (act == actPush) modelMem[arr][modelSize[arr]] = val;
          modelSize[arr]++;
        end
      end
      actDec, actPop: begin
        hasData = (act == actPop);
        if (err == errNone && modelSize[arr] == 0) err = errEmpty;
        if (err == errNone) begin
          modelSize[arr]--;
          result = modelMem[arr][modelSize[arr]];   // Top element
        end
      end
      actResize: begin
        hasData = 1'b0;
        if (err == errNone && int'(val) > arrayLength) err = errBounds;
        if (err == errNone) modelSize[arr] = int'(val);
      end
      actAlloc: begin
        err  = errNone;
        slot = 0;
        if (modelFreed.size() > 0) begin
          slot = modelFreed.pop_back();              // Reuse first
        end else if (modelHandedOut < arrayCount) begin
          slot = modelHandedOut;
          modelHandedOut++;
        end else begin
          err = errNoMemory;
        end
        if (err == errNone) begin
          modelAllocated[slot] = 1'b1;
          modelSize[slot]      = 0;
          result               = elemData'(slot);
        end
      end
      actFree: begin
        hasData = 1'b0;
        if (err == errNone) begin
          modelAllocated[arr] = 1'b0;
          modelFreed.push_back(arr);
        end
      end
      actAdd, actAddAfter, actSub, actSubAfter, actShl, actShr,
      actLNot, actNot, actOr, actXor, actAnd: begin
        err = readErr;
        if (err == errNone) begin
          old                = modelMem[arr][idx];
          modelMem[arr][idx] = applyOp(act, old, val);
          result = (act == actAddAfter || act == actSubAfter) ? old : modelMem[arr][idx];
        end
      end
      default: err = errBadAction;
    endcase
    if (err == errNone && hasData) modelLast = result;  // Failures keep dataOut
    expErr  = err;
    expData = modelLast;
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic allocAndFree();
    for (int i = 0; i < arrayCount; i++) sendRequest(actAlloc, 0, 0, '0);  // Arrays 0 to 3
    sendRequest(actAlloc, 0, 0, '0);                 // Nothing left
    sendRequest(actFree, 2, 0, '0);
    sendRequest(actAlloc, 0, 0, '0);
    checkValue("dataOut", 16'(2), 16'(dataOut));     // Freed array comes back
    sendRequest(actFree, 2, 0, '0);
    sendRequest(actFree, 2, 0, '0);                  // Already freed
    checkValue("error", 16'(errFreed), 16'(error));
    sendRequest(actAlloc, 0, 0, '0);
    sendRequest(actClear, 0, 0, '0);
    for (int i = 0; i < arrayCount; i++) sendRequest(actSize, i, 0, '0);
    reportTest("allocAndFree");
  endtask

  task automatic writeAndRead();
    sendRequest(actClear, 0, 0, '0);
    for (int a = 0; a < arrayCount; a++) begin
      sendRequest(actAlloc, 0, 0, '0);
      for (int i = 0; i < arrayLength; i++) sendRequest(actWrite, a, i, elemData'($urandom));
      sendRequest(actSize, a, 0, '0);
    end
    sendRequest(actClear, 0, 0, '0);                 // Sizes back to zero, elements kept
    for (int a = 0; a < arrayCount; a++) sendRequest(actAlloc, 0, 0, '0);
    sendRequest(actWrite, 1, 5, elemData'($urandom));  // Size grows to 6
    sendRequest(actSize, 1, 0, '0);
    sendRequest(actRead, 1, 5, '0);
    sendRequest(actRead, 1, 2, '0);
    sendRequest(actRead, 1, 6, '0);                  // Past the end
    sendRequest(actResize, 2, 0, elemData'(7));
    sendRequest(actInc, 2, 0, '0);
    sendRequest(actInc, 2, 0, '0);                   // Full
    sendRequest(actSize, 2, 0, '0);
    sendRequest(actResize, 2, 0, elemData'(9));      // Beyond max length
    sendRequest(actResize, 2, 0, elemData'(1));
    sendRequest(actDec, 2, 0, '0);
    sendRequest(actDec, 2, 0, '0);                   // Empty
    sendRequest(actSize, 2, 0, '0);
    reportTest("writeAndRead");
  endtask

  task automatic pushAndPop();
    elemData pushed [$];
    elemData value;
    elemData held;
    for (int i = 0; i < arrayLength; i++) begin
      value = elemData'($urandom);
      pushed.push_back(value);
      sendRequest(actPush, 3, 0, value);
    end
    sendRequest(actPush, 3, 0, elemData'($urandom)); // Full
    held = pushed[0];                                // Last pop gives the first push
    for (int i = 0; i < arrayLength; i++) begin
      sendRequest(actPop, 3, 0, '0);
      checkValue("dataOut", 16'(pushed.pop_back()), 16'(dataOut));  // Reverse order
    end
    sendRequest(actPop, 3, 0, '0);                   // Empty
    checkValue("dataOut", 16'(held), 16'(dataOut));
    reportTest("pushAndPop");
  endtask

  task automatic elementOps();
    heapAction opList [11];
    int        idx;
    elemData   val;
    opList = '{actAdd, actAddAfter, actSub, actSubAfter, actShl, actShr,
               actLNot, actNot, actOr, actXor, actAnd};
    for (int i = 0; i < arrayLength; i++) sendRequest(actWrite, 0, i, elemData'($urandom));
    sendRequest(actWrite, 0, 7, '0);
    sendRequest(actLNot, 0, 7, '0);                  // Zero turns to one
    sendRequest(actLNot, 0, 7, '0);
    for (int r = 0; r < 3; r++) begin
      foreach (opList[k]) begin
        idx = $urandom % arrayLength;
        val = elemData'($urandom);
        if (opList[k] == actShl || opList[k] == actShr) val = elemData'($urandom % 14);
        sendRequest(opList[k], 0, idx, val);
        if (opList[k] == actAddAfter || opList[k] == actSubAfter) begin
          sendRequest(actRead, 0, idx, '0);          // New value stored
        end
      end
    end
    reportTest("elementOps");
  endtask

  task automatic backToBack();
    heapAction acts    [11];
    int        arrs    [11];
    int        idxs    [11];
    elemData   vals    [11];
    heapError  expErrs [11];
    elemData   expVals [11];
    int        n;
    int        seen;
    acts = '{actWrite, actRead, actAdd, actRead, actPush, actPop, actSize,
             actAddAfter, actRead, actWrite, actSize};
    arrs = '{1, 1, 1, 1, 2, 2, 2, 1, 1, 3, 3};
    idxs = '{2, 2, 2, 2, 0, 0, 0, 2, 2, 0, 0};
    n    = 11;
    seen = 0;
    foreach (vals[k]) vals[k] = elemData'($urandom);
    foreach (acts[k]) modelStep(acts[k], arrs[k], idxs[k], vals[k], expErrs[k], expVals[k]);
    @(negedge clock);
    for (int c = 0; c < n + 6; c++) begin
      checkValue("done", 16'(c >= 4 && c < n + 4), 16'(done));  // Three edges after start
      if (done && seen < n) begin
        checkValue("error", 16'(expErrs[seen]), 16'(error));
        checkValue("dataOut", 16'(expVals[seen]), 16'(dataOut));
        seen++;
      end
      start = (c < n);
      if (c < n) begin
        action = acts[c];
        array  = arrayNum'(arrs[c]);
        index  = elemIndex'(idxs[c]);
        dataIn = vals[c];
      end
      @(negedge clock);
    end
    requestCount += n;
    testRequests += n;
    reportTest("backToBack");
  endtask

  task automatic badActions();
    logic [7:0] codes [5];
    codes = '{8'd0, 8'd7, 8'd16, 8'd31, 8'd255};
    foreach (codes[k]) begin
      sendRequest(heapAction'(codes[k]), k % arrayCount, k, elemData'($urandom));
      checkValue("error", 16'(errBadAction), 16'(error));
    end
    for (int a = 0; a < arrayCount; a++) sendRequest(actSize, a, 0, '0);  // Sizes untouched
    foreach (codes[k]) sendRequest(actRead, k % arrayCount, k, '0);    // Elements untouched
    reportTest("badActions");
  endtask

`endif

// File: verif/heapArrayTb.sv
// Testbench top for the array heap
// Clock, reset, DUT instance, request helper, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module heapArrayTb;
  import heapPkg::*;

  localparam int clockPeriod    = 40;
  localparam int resetCycles    = 16;
  localparam int maxRequests    = 300;  // Bound over all tests
  localparam int watchdogCycles = maxRequests * 4 + resetCycles + 200;
  localparam int doneLimit      = 8;    // Cycles to wait for done

  logic      clock;
  logic      resetN;
  logic      start;
  heapAction action;
  arrayNum   array;
  elemIndex  index;
  elemData   dataIn;
  elemData   dataOut;
  heapError  error;
  logic      done;

  int errorCount   = 0;
  int checkCount   = 0;
  int requestCount = 0;
  int testCount    = 0;
  int testErrors   = 0;  // Per test
  int testRequests = 0;

  heapArray heapArray_i (
    .clock   (clock),
    .resetN  (resetN),
    .start   (start),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .error   (error),
    .done    (done)
  );

  initial clock = 1'b0;
  always #(clockPeriod / 2) clock = ~clock;

  // --------------------
  // Helpers
  // --------------------
  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, name, expected, actual);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic sendRequest(input heapAction act, input int arr, input int idx,
                             input elemData val);
    heapError expErr;
    elemData  expData;
    int       waitCycles;
    modelStep(act, arr, idx, val, expErr, expData);  // Expected response first
    @(negedge clock);
    start  = 1'b1;
    action = act;
    array  = arrayNum'(arr);
    index  = elemIndex'(idx);
    dataIn = val;
    @(negedge clock);
    start      = 1'b0;
    waitCycles = 0;
    while (!done && waitCycles < doneLimit) begin
      @(negedge clock);
      waitCycles++;
    end
    requestCount++;
    testRequests++;
    assert (done) else begin
      $display("%0t ns: no done pulse within %0d cycles of action %0d", $time, doneLimit, act);
      errorCount++;
      testErrors++;
    end
    if (done) begin
      checkValue("error", 16'(expErr), 16'(error));
      checkValue("dataOut", 16'(expData), 16'(dataOut));
    end
  endtask

  task automatic reportTest(input string name);
    testCount++;
    $display("%0t ns %s: %0d requests, %0d errors", $time, name, testRequests, testErrors);
    testErrors   = 0;
    testRequests = 0;
  endtask

  `include "heapArrayTests.svh"

  // --------------------
  // Sequence
  // --------------------
  initial begin
    void'($urandom(91679));
    resetN = 1'b0;
    start  = 1'b0;
    action = actClear;
    array  = '0;
    index  = '0;
    dataIn = '0;
    repeat (resetCycles) @(negedge clock);
    checkValue("done", 16'(0), 16'(done));           // Reset values
    checkValue("error", 16'(errNone), 16'(error));
    checkValue("dataOut", 16'(0), 16'(dataOut));
    resetN = 1'b1;
    allocAndFree();
    writeAndRead();
    pushAndPop();
    elementOps();
    backToBack();
    badActions();
    repeat (4) @(negedge clock);
    $display("Summary: %0d tests, %0d requests, %0d checks, %0d errors",
             testCount, requestCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdogCycles) @(posedge clock);
    $display("Watchdog: run still going after %0d cycles", watchdogCycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
